/* hw/fetch_pkg.sv */
// shared widths, reset pc, memory sizing, jal opcode
// instruction union with base and J-format views, jal target helper
package fetch_pkg;

  localparam int XLEN      = 64;
  localparam int INST_W    = 32;
  localparam int MEM_WORDS = 256;
  localparam int MEM_IDX_W = $clog2(MEM_WORDS);
  localparam int JIMM_W    = 21;             // J immediate incl. implied bit 0

  typedef logic [XLEN-1:0]      addr_t;
  typedef logic [MEM_IDX_W-1:0] mem_idx_t;

  localparam addr_t       PC_START = 64'h8000_0000;
  localparam addr_t       PC_STEP  = 64'd4;  // one instruction
  localparam logic [6:0]  OP_JAL   = 7'b1101111;

  typedef struct packed {
    logic [INST_W-8:0] upper;
    logic [6:0]        opcode;
  } inst_base_t;

  // J-format, immediate bits scrambled as in the ISA
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } inst_j_t;

  typedef union packed {
    inst_base_t base;
    inst_j_t    j;
  } inst_t;

  // pc + sign extended J immediate
  function automatic addr_t jal_target(inst_t inst, addr_t pc);
    logic [JIMM_W-1:0] imm;
    imm = {inst.j.imm_20, inst.j.imm_19_12, inst.j.imm_11, inst.j.imm_10_1, 1'b0};
    return pc + {{(XLEN-JIMM_W){imm[JIMM_W-1]}}, imm};
  endfunction

endpackage

/* hw/fetch_bus_if.sv */
// fetch request bus between fetch unit and instruction memory
interface fetch_bus_if;

  logic             req;    // level, held until ack
  fetch_pkg::addr_t addr;   // stable while req is high
  logic             ack;    // single cycle per request
  fetch_pkg::inst_t rdata;  // valid with ack

  // fetch side
  modport fetcher (
    output req,
    output addr,
    input  ack,
    input  rdata
  );

  // memory side
  modport memory (
    input  req,
    input  addr,
    output ack,
    output rdata
  );

endinterface

/* hw/fetch_unit.sv */
// fetch FSM: request level, pc prediction, wrong-path discard and refetch
// publishes each fetched word with its pc for one cycle
module fetch_unit (
  input  logic                clk,
  input  logic                rst,

  fetch_bus_if.fetcher        bus,

  input  logic                i_retire,    // previous instruction done
  input  logic                i_jmp,
  input  fetch_pkg::addr_t    i_jmp_addr,
  output fetch_pkg::addr_t    o_pc,
  output fetch_pkg::inst_t    o_inst,
  output logic                o_fetched
);

  logic             handshake;
  logic             mispredict;
  logic             redirect;       // next handshake is wrong path
  fetch_pkg::addr_t pc_pred;        // last fetched pc + 4
  fetch_pkg::addr_t saved_target;

  assign handshake  = bus.req & bus.ack;
  assign mispredict = i_jmp & (i_jmp_addr != pc_pred);

  //////////////////////////////////////////////////////////////////////
  // request control

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.req <= 1'b1;              // first fetch right out of reset
    end else if (handshake) begin
      bus.req <= redirect;          // keep asking when refetching
    end else if (i_retire) begin
      bus.req <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // jump redirect

  always_ff @(posedge clk) begin
    if (rst) begin
      redirect <= 1'b0;
    end else if (handshake) begin
      redirect <= 1'b0;             // wrong-path word consumed
    end else if (mispredict) begin
      redirect <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (mispredict) begin
      saved_target <= i_jmp_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // address, prediction and publish

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.addr  <= fetch_pkg::PC_START;
      pc_pred   <= fetch_pkg::PC_START;
      o_fetched <= 1'b0;
    end else begin
      o_fetched <= handshake & ~redirect;
      if (handshake) begin
        if (redirect) begin
          bus.addr <= saved_target;     // drop data, go to target
        end else begin
          bus.addr <= bus.addr + fetch_pkg::PC_STEP;
          pc_pred  <= bus.addr + fetch_pkg::PC_STEP;
        end
      end
    end
  end

  // payload toward the later stages
  always_ff @(posedge clk) begin
    if (handshake & ~redirect) begin
      o_pc   <= bus.addr;
      o_inst <= bus.rdata;
    end
  end

endmodule

/* hw/inst_mem.sv */
// instruction memory with load port, external stall and registered ack
module inst_mem (
  input  logic                clk,
  input  logic                rst,

  fetch_bus_if.memory         bus,

  input  logic                i_stall,
  input  logic                i_load_we,
  input  fetch_pkg::mem_idx_t i_load_idx,
  input  fetch_pkg::inst_t    i_load_data
);

  fetch_pkg::inst_t    mem [fetch_pkg::MEM_WORDS];
  fetch_pkg::mem_idx_t rd_idx;
  logic                ack_set;

  // word index, wraps every 1 KiB
  assign rd_idx  = bus.addr[fetch_pkg::MEM_IDX_W+1:2];

  // one ack per request, held off while stalled
  assign ack_set = bus.req & ~bus.ack & ~i_stall;

  //////////////////////////////////////////////////////////////////////
  // storage

  always_ff @(posedge clk) begin
    if (i_load_we) begin
      mem[i_load_idx] <= i_load_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.ack <= 1'b0;
    end else begin
      bus.ack <= ack_set;
    end
  end

  always_ff @(posedge clk) begin
    if (ack_set) begin
      bus.rdata <= mem[rd_idx];   // captured with the ack
    end
  end

endmodule

/* hw/jump_resolver.sv */
// stand-in for the later stages: holds each fetched word for one cycle,
// retires it and reports the JAL target
module jump_resolver (
  input  logic              clk,
  input  logic              rst,

  input  logic              i_fetched,
  input  fetch_pkg::addr_t  i_pc,
  input  fetch_pkg::inst_t  i_inst,

  output logic              o_retire,
  output logic              o_jmp,
  output fetch_pkg::addr_t  o_jmp_addr
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::inst_t inst_q;
  logic             retire_q;
  logic             is_jal;

  //////////////////////////////////////////////////////////////////////
  // capture

  always_ff @(posedge clk) begin
    if (rst) begin
      retire_q <= 1'b0;
    end else begin
      retire_q <= i_fetched;          // retire one cycle after fetch
    end
  end

  always_ff @(posedge clk) begin
    if (i_fetched) begin
      pc_q   <= i_pc;
      inst_q <= i_inst;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // decode

  // opcode through the base view
  assign is_jal = (inst_q.base.opcode == fetch_pkg::OP_JAL);

  assign o_retire = retire_q;
  assign o_jmp    = retire_q & is_jal;

  // immediate through the J view, valid while o_retire is high
  assign o_jmp_addr = fetch_pkg::jal_target(inst_q, pc_q);

endmodule

/* hw/fetch_top.sv */
// fetch loop top: fetch unit, instruction memory and jump resolver
// joined through the fetch bus
module fetch_top (
  input  logic                clk,
  input  logic                rst,

  // program load
  input  logic                i_load_we,
  input  fetch_pkg::mem_idx_t i_load_idx,
  input  fetch_pkg::inst_t    i_load_data,

  input  logic                i_mem_stall,

  // fetched stream
  output logic                o_fetched,
  output fetch_pkg::addr_t    o_pc,
  output fetch_pkg::inst_t    o_inst,

  // retire side
  output logic                o_retire,
  output logic                o_jmp,
  output fetch_pkg::addr_t    o_jmp_addr
);

  fetch_bus_if i_bus ();

  fetch_unit i_fetch_unit (
    .clk        (clk),
    .rst        (rst),
    .bus        (i_bus.fetcher),
    .i_retire   (o_retire),
    .i_jmp      (o_jmp),
    .i_jmp_addr (o_jmp_addr),
    .o_pc       (o_pc),
    .o_inst     (o_inst),
    .o_fetched  (o_fetched)
  );

  inst_mem i_inst_mem (
    .clk         (clk),
    .rst         (rst),
    .bus         (i_bus.memory),
    .i_stall     (i_mem_stall),
    .i_load_we   (i_load_we),
    .i_load_idx  (i_load_idx),
    .i_load_data (i_load_data)
  );

  jump_resolver i_jump_resolver (
    .clk        (clk),
    .rst        (rst),
    .i_fetched  (o_fetched),
    .i_pc       (o_pc),
    .i_inst     (o_inst),
    .o_retire   (o_retire),
    .o_jmp      (o_jmp),
    .o_jmp_addr (o_jmp_addr)
  );

endmodule

/* tb/tb_fetch_top.sv */
// testbench for fetch_top: random program and memory stalls,
// ISA-level model of the fetched stream and the JAL redirects
module tb_fetch_top;

  localparam int          N_FETCH        = 400;
  localparam int          RESET_CYCLES   = 5;
  localparam int          TIMEOUT_CYCLES = N_FETCH * 16 + 300;  // slow loop plus slack
  localparam int          MAX_STALL_RUN  = 3;
  localparam logic [31:0] SEED           = 32'hbf66_d2fb;

  logic                clk;
  logic                rst;
  logic                load_we;
  fetch_pkg::mem_idx_t load_idx;
  fetch_pkg::inst_t    load_data;
  logic                mem_stall;
  logic                fetched;
  fetch_pkg::addr_t    pc;
  fetch_pkg::inst_t    inst;
  logic                retire;
  logic                jmp;
  fetch_pkg::addr_t    jmp_addr;

  logic [31:0]      rng_state;
  logic [31:0]      prog [fetch_pkg::MEM_WORDS];  // model copy of the memory
  fetch_pkg::addr_t model_pc;
  logic             exp_jmp;                      // for the pending retire
  fetch_pkg::addr_t exp_target;
  logic             fetched_q;                    // o_fetched one cycle back
  int               stall_run;
  int               n_fetched;
  int               n_retired;
  int               n_redirect;
  int               n_jal_seq;
  int               cycle_cnt = 0;

  fetch_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .i_load_we   (load_we),
    .i_load_idx  (load_idx),
    .i_load_data (load_data),
    .i_mem_stall (mem_stall),
    .o_fetched   (fetched),
    .o_pc        (pc),
    .o_inst      (inst),
    .o_retire    (retire),
    .o_jmp       (jmp),
    .o_jmp_addr  (jmp_addr)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // random numbers and program

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand32();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic logic [31:0] make_jal(input logic [31:0] r);
    int          off;
    logic [20:0] imm;
    if (r[2:0] == 3'd0) begin
      off = 4;                        // lands on the fall-through pc
    end else begin
      off = (int'(r[6:3]) + 1) * 4;   // 4..64 bytes
      if (r[7]) begin
        off = -off;
      end
    end
    imm = 21'(off);
    return {imm[20], imm[10:1], imm[11], imm[19:12], r[12:8], fetch_pkg::OP_JAL};
  endfunction

  task automatic gen_program();
    logic [31:0] r;
    logic [31:0] w;
    for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
      r = rand32();
      if (r[1:0] == 2'b00) begin
        w = make_jal(rand32());
      end else begin
        w = rand32();
        if (w[6:0] == fetch_pkg::OP_JAL) begin
          w[0] = 1'b0;                // any other opcode
        end
      end
      prog[i] = w;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // reference model and checks

  function automatic logic is_jal(input logic [31:0] w);
    return w[6:0] == 7'b1101111;
  endfunction

  // J immediate gathered from the scrambled ISA bit positions
  function automatic fetch_pkg::addr_t jump_dest(input fetch_pkg::addr_t at,
                                                 input logic [31:0] w);
    logic [20:0] imm;
    imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    return at + {{43{imm[20]}}, imm};
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] %s: got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_pc(input fetch_pkg::addr_t got, input fetch_pkg::addr_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] o_pc: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_inst(input fetch_pkg::inst_t got, input fetch_pkg::inst_t exp);
    if (got !== exp) begin
      fail_run($sformatf("[FAIL] o_inst: got %h expected %h", got, exp));
    end
  endtask

  task automatic check_jump(input logic got_jmp, input fetch_pkg::addr_t got_addr,
                            input logic exp_j, input fetch_pkg::addr_t exp_addr);
    if (got_jmp !== exp_j) begin
      fail_run($sformatf("[FAIL] o_jmp: got %h expected %h", got_jmp, exp_j));
    end else if (exp_j && (got_addr !== exp_addr)) begin
      fail_run($sformatf("[FAIL] o_jmp_addr: got %h expected %h", got_addr, exp_addr));
    end
  endtask

  task automatic step_model();
    logic [31:0]      w;
    fetch_pkg::addr_t fall;
    w = prog[model_pc[9:2]];          // same 1 KiB wrap as the memory
    check_pc(pc, model_pc);
    check_inst(inst, w);
    fall       = model_pc + 64'd4;
    exp_jmp    = is_jal(w);
    exp_target = jump_dest(model_pc, w);
    if (exp_jmp) begin
      if (exp_target != fall) begin
        n_redirect++;
      end else begin
        n_jal_seq++;
      end
      model_pc = exp_target;
    end else begin
      model_pc = fall;
    end
    n_fetched++;
  endtask

  task automatic check_cycle();
    check_flag("o_retire", retire, fetched_q);  // exactly one cycle after fetch
    if (retire) begin
      check_jump(jmp, jmp_addr, exp_jmp, exp_target);
      n_retired++;
    end else begin
      check_flag("o_jmp", jmp, 1'b0);
    end
    if (fetched) begin
      if (fetched_q) begin
        fail_run("second instruction fetched before the previous one retired");
      end else begin
        step_model();
      end
    end
    fetched_q = fetched;
  endtask

  task automatic drive_stall();
    logic [31:0] r;
    r = rand32();
    if (stall_run >= MAX_STALL_RUN) begin
      mem_stall = 1'b0;
    end else begin
      mem_stall = (r[1:0] == 2'b00);  // about one cycle in four
    end
    stall_run = mem_stall ? stall_run + 1 : 0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // run

  always @(posedge clk) begin
    if (!rst) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        fail_run($sformatf("timeout after %0d cycles with %0d instructions fetched",
                           cycle_cnt, n_fetched));
      end
    end
  end

  initial begin
    rst        = 1'b1;
    load_we    = 1'b0;
    load_idx   = '0;
    load_data  = '0;
    mem_stall  = 1'b0;
    rng_state  = SEED;
    model_pc   = fetch_pkg::PC_START;
    exp_jmp    = 1'b0;
    exp_target = '0;
    fetched_q  = 1'b0;
    stall_run  = 0;
    n_fetched  = 0;
    n_retired  = 0;
    n_redirect = 0;
    n_jal_seq  = 0;
    gen_program();

    // program goes in while the fetch loop sits in reset
    for (int i = 0; i < fetch_pkg::MEM_WORDS; i++) begin
      @(negedge clk);
      load_we   = 1'b1;
      load_idx  = fetch_pkg::mem_idx_t'(i);
      load_data = prog[i];
    end
    @(negedge clk);
    load_we = 1'b0;
    repeat (RESET_CYCLES) begin
      @(negedge clk);
      check_flag("o_fetched", fetched, 1'b0);
      check_flag("o_retire", retire, 1'b0);
      check_flag("o_jmp", jmp, 1'b0);
    end
    rst = 1'b0;

    @(negedge clk);                   // first cycle out of reset
    check_flag("o_fetched", fetched, 1'b0);
    check_flag("o_retire", retire, 1'b0);
    check_flag("o_jmp", jmp, 1'b0);
    drive_stall();

    while ((n_fetched < N_FETCH) || fetched_q) begin
      @(negedge clk);
      check_cycle();
      drive_stall();
    end

    $display("fetched %0d, retired %0d, redirects %0d, jal to pc+4 %0d, cycles %0d",
             n_fetched, n_retired, n_redirect, n_jal_seq, cycle_cnt);
    $display("Simulation passed");
    $finish;
  end

endmodule

/* project.f */
hw/fetch_pkg.sv
hw/fetch_bus_if.sv
hw/fetch_unit.sv
hw/inst_mem.sv
hw/jump_resolver.sv
hw/fetch_top.sv
tb/tb_fetch_top.sv

/* run_sim.sh */
#!/bin/sh
# builds the fetch loop testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f project.f --top-module tb_fetch_top \
    -Mdir obj_dir -o sim_fetch; then
  echo "run_sim: build failed"
  exit 1
fi

out=$(./obj_dir/sim_fetch 2>&1)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
  echo "run_sim: simulator exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx 'Simulation passed'; then
  echo "run_sim: PASS"
  exit 0
fi

echo "run_sim: FAIL"
exit 1
